//--- src/regfile_pkg.sv
/*
 * Register file package
 * Widths, operand size codes, x86 register numbers, the register word
 * union and the port structs shared across the register file.
 */
`default_nettype none

package regfile_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_COUNT = 8;
    localparam int REG_IDX_W = 3;

    // operand size codes, code 3 is reserved
    typedef enum logic [1:0] {
        SIZE_32   = 2'd0,
        SIZE_16   = 2'd1,
        SIZE_8    = 2'd2,
        SIZE_RSVD = 2'd3
    } op_size_e;

    // standard x86 encoding order
    localparam logic [REG_IDX_W-1:0] REG_EAX = 3'd0;
    localparam logic [REG_IDX_W-1:0] REG_ECX = 3'd1;
    localparam logic [REG_IDX_W-1:0] REG_EDX = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_EBX = 3'd3;
    localparam logic [REG_IDX_W-1:0] REG_ESP = 3'd4;
    localparam logic [REG_IDX_W-1:0] REG_EBP = 3'd5;
    localparam logic [REG_IDX_W-1:0] REG_ESI = 3'd6;
    localparam logic [REG_IDX_W-1:0] REG_EDI = 3'd7;

    // ----------------------------------------------------------
    // register word and state
    // ----------------------------------------------------------

    // upper half, then AH-style high byte, then AL-style low byte
    typedef struct packed {
        logic [15:0] upper;
        logic [7:0]  high;
        logic [7:0]  low;
    } reg_parts_t;

    typedef union packed {
        logic [DATA_W-1:0] dword;
        reg_parts_t        parts;
    } reg_word_u;

    typedef reg_word_u [REG_COUNT-1:0] reg_array_t;

    // ----------------------------------------------------------
    // port structs
    // ----------------------------------------------------------

    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] reg_num;
        op_size_e             size;
        logic [DATA_W-1:0]    data;
    } wb_req_t;

    // writeback already resolved to a physical register and full word
    typedef struct packed {
        logic                 en;
        logic [REG_IDX_W-1:0] idx;
        logic [DATA_W-1:0]    data;
    } gpr_write_t;

    typedef struct packed {
        logic              esi_en;
        logic [DATA_W-1:0] esi_data;
        logic              edi_en;
        logic [DATA_W-1:0] edi_data;
    } str_load_t;

    typedef struct packed {
        logic              en;
        logic [DATA_W-1:0] data;
    } esp_write_t;

endpackage

`default_nettype wire

//--- src/operand_read_port.sv
/*
 * Operand read port
 * Sized read of one register, with the 8-bit AH/CH/DH/BH aliases
 * mapped onto the high bytes of registers 0 to 3.
 */
`timescale 1ns/1ps
`default_nettype none

module operand_read_port (
    input  regfile_pkg::reg_array_t            state,
    input  logic [regfile_pkg::REG_IDX_W-1:0]  reg_num,
    input  regfile_pkg::op_size_e              size,
    output logic [regfile_pkg::DATA_W-1:0]     value
);

    regfile_pkg::reg_word_u sel_word;
    regfile_pkg::reg_word_u byte_word;
    logic                   high_alias;

    // at 8-bit size codes 4..7 name the high byte of registers 0..3
    assign high_alias = reg_num[2];
    assign sel_word   = state[reg_num];
    assign byte_word  = state[{1'b0, reg_num[1:0]}];

    always_comb begin
        // zero extension by default, reserved size reads as zero
        value = '0;
        case (size)
            regfile_pkg::SIZE_32: begin
                value = sel_word.dword;
            end
            regfile_pkg::SIZE_16: begin
                value[15:0] = {sel_word.parts.high, sel_word.parts.low};
            end
            regfile_pkg::SIZE_8: begin
                if (high_alias) begin
                    value[7:0] = byte_word.parts.high;
                end else begin
                    value[7:0] = byte_word.parts.low;
                end
            end
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/writeback_merge.sv
/*
 * Writeback merge
 * Resolves the physical target of a sized writeback and overlays the
 * data field onto the old register word, keeping the untouched bits.
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_merge (
    input  regfile_pkg::reg_array_t  state,
    input  regfile_pkg::wb_req_t     req,
    output regfile_pkg::gpr_write_t  wr
);

    logic [regfile_pkg::REG_IDX_W-1:0] target;
    logic                              size_ok;
    regfile_pkg::reg_word_u            old_word;
    regfile_pkg::reg_word_u            new_word;

    // ----------------------------------------------------------
    // target select
    // ----------------------------------------------------------

    // byte writes to codes 4..7 land in registers 0..3
    always_comb begin
        target = req.reg_num;
        if (req.size == regfile_pkg::SIZE_8) begin
            target = {1'b0, req.reg_num[1:0]};
        end
    end

    assign old_word = state[target];
    assign size_ok  = (req.size != regfile_pkg::SIZE_RSVD);

    // ----------------------------------------------------------
    // field overlay
    // ----------------------------------------------------------

    always_comb begin
        new_word = old_word;
        case (req.size)
            regfile_pkg::SIZE_32: begin
                new_word.dword = req.data;
            end
            regfile_pkg::SIZE_16: begin
                {new_word.parts.high, new_word.parts.low} = req.data[15:0];
            end
            regfile_pkg::SIZE_8: begin
                // high byte alias keeps AL intact and vice versa
                if (req.reg_num[2]) begin
                    new_word.parts.high = req.data[7:0];
                end else begin
                    new_word.parts.low = req.data[7:0];
                end
            end
            default: begin
                new_word = old_word;
            end
        endcase
    end

    always_comb begin
        wr.en   = req.en && size_ok;
        wr.idx  = target;
        wr.data = new_word.dword;
    end

endmodule

`default_nettype wire

//--- src/gpr_bank.sv
/*
 * General purpose register bank
 * Eight 32-bit registers cleared on reset, loaded from the merged
 * writeback, the string pointer loads and the stack pointer write.
 */
`timescale 1ns/1ps
`default_nettype none

module gpr_bank (
    input  logic                     clk,
    input  logic                     arst_n,
    input  regfile_pkg::gpr_write_t  wr,
    input  regfile_pkg::str_load_t   str_load,
    input  regfile_pkg::esp_write_t  esp_write,
    output regfile_pkg::reg_array_t  state
);

    regfile_pkg::reg_array_t             regs;
    regfile_pkg::reg_array_t             regs_next;
    logic [regfile_pkg::REG_COUNT-1:0]   wb_hit;

    // ----------------------------------------------------------
    // next state with load priorities
    // ----------------------------------------------------------

    always_comb begin
        regs_next = regs;

        // one-hot decode of the writeback target
        for (int i = 0; i < regfile_pkg::REG_COUNT; i++) begin
            wb_hit[i] = wr.en && (wr.idx == regfile_pkg::REG_IDX_W'(i));
            if (wb_hit[i]) begin
                regs_next[i].dword = wr.data;
            end
        end

        // stack write yields to a writeback on ESP
        if (esp_write.en && !wb_hit[regfile_pkg::REG_ESP]) begin
            regs_next[regfile_pkg::REG_ESP].dword = esp_write.data;
        end

        // string pointer loads override any writeback
        if (str_load.esi_en) begin
            regs_next[regfile_pkg::REG_ESI].dword = str_load.esi_data;
        end
        if (str_load.edi_en) begin
            regs_next[regfile_pkg::REG_EDI].dword = str_load.edi_data;
        end
    end

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '0;
        end else begin
            regs <= regs_next;
        end
    end

    assign state = regs;

endmodule

`default_nettype wire

//--- src/register_file.sv
/*
 * x86 general purpose register file
 * Two sized operand reads, two full-width SIB reads, one merging
 * writeback port plus direct ESI/EDI and ESP updates.
 */
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                               clk,
    input  logic                               arst_n,
    input  regfile_pkg::op_size_e              register_size,
    input  logic [regfile_pkg::REG_IDX_W-1:0]  op_1,
    input  logic [regfile_pkg::REG_IDX_W-1:0]  op_2,
    input  logic [regfile_pkg::REG_IDX_W-1:0]  sib_base_reg,
    input  logic [regfile_pkg::REG_IDX_W-1:0]  sib_index_reg,
    input  regfile_pkg::wb_req_t               writeback,
    input  regfile_pkg::str_load_t             str_load,
    input  regfile_pkg::esp_write_t            esp_write,
    output logic [regfile_pkg::DATA_W-1:0]     op_1_value,
    output logic [regfile_pkg::DATA_W-1:0]     op_2_value,
    output logic [regfile_pkg::DATA_W-1:0]     sib_base_value,
    output logic [regfile_pkg::DATA_W-1:0]     sib_index_value,
    output regfile_pkg::reg_array_t            gpr_state
);

    regfile_pkg::reg_array_t   state;
    regfile_pkg::gpr_write_t   bank_wr;

    // ----------------------------------------------------------
    // operand reads, both share one size
    // ----------------------------------------------------------

    operand_read_port u_op1_read (
        .state   (state),
        .reg_num (op_1),
        .size    (register_size),
        .value   (op_1_value)
    );

    operand_read_port u_op2_read (
        .state   (state),
        .reg_num (op_2),
        .size    (register_size),
        .value   (op_2_value)
    );

    // SIB base and index are always full width
    assign sib_base_value  = state[sib_base_reg].dword;
    assign sib_index_value = state[sib_index_reg].dword;

    // ----------------------------------------------------------
    // writeback path and storage
    // ----------------------------------------------------------

    writeback_merge u_wb_merge (
        .state (state),
        .req   (writeback),
        .wr    (bank_wr)
    );

    gpr_bank u_bank (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (bank_wr),
        .str_load  (str_load),
        .esp_write (esp_write),
        .state     (state)
    );

    assign gpr_state = state;

endmodule

`default_nettype wire

//--- verification/register_file_tb.sv
/*
 * Register file testbench
 * Drives directed and random traffic into the register file and checks
 * every output each cycle against a shadow model of the eight registers.
 */
`timescale 1ns/1ps
`default_nettype none

module register_file_tb;

    localparam int SWEEP_CYCLES    = 32;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 6 * SWEEP_CYCLES + 40;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES);

    typedef logic [regfile_pkg::REG_COUNT-1:0][regfile_pkg::DATA_W-1:0] model_t;

    logic                                clk = 1'b0;
    logic                                arst_n;
    regfile_pkg::op_size_e               register_size;
    logic [regfile_pkg::REG_IDX_W-1:0]   op_1;
    logic [regfile_pkg::REG_IDX_W-1:0]   op_2;
    logic [regfile_pkg::REG_IDX_W-1:0]   sib_base_reg;
    logic [regfile_pkg::REG_IDX_W-1:0]   sib_index_reg;
    regfile_pkg::wb_req_t                writeback;
    regfile_pkg::str_load_t              str_load;
    regfile_pkg::esp_write_t             esp_write;
    logic [regfile_pkg::DATA_W-1:0]      op_1_value;
    logic [regfile_pkg::DATA_W-1:0]      op_2_value;
    logic [regfile_pkg::DATA_W-1:0]      sib_base_value;
    logic [regfile_pkg::DATA_W-1:0]      sib_index_value;
    regfile_pkg::reg_array_t             gpr_state;

    model_t       shadow;
    logic         checking = 1'b0;
    int           seed;
    int           cycle_count = 0;
    int           checked_cycles = 0;
    int           mismatch_count = 0;
    int           timeout_count = 0;
    logic [31:0]  rnd;

    register_file u_dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .register_size   (register_size),
        .op_1            (op_1),
        .op_2            (op_2),
        .sib_base_reg    (sib_base_reg),
        .sib_index_reg   (sib_index_reg),
        .writeback       (writeback),
        .str_load        (str_load),
        .esp_write       (esp_write),
        .op_1_value      (op_1_value),
        .op_2_value      (op_2_value),
        .sib_base_value  (sib_base_value),
        .sib_index_value (sib_index_value),
        .gpr_state       (gpr_state)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic model_t next_state(input model_t cur, input regfile_pkg::wb_req_t wb,
                                          input regfile_pkg::str_load_t sl,
                                          input regfile_pkg::esp_write_t ew);
        model_t nxt;
        logic   wb_on_esp;
        nxt       = cur;
        wb_on_esp = 1'b0;
        if (wb.en) begin
            case (wb.size)
                regfile_pkg::SIZE_32: begin
                    nxt[wb.reg_num] = wb.data;
                    wb_on_esp = (wb.reg_num == 3'd4);
                end
                regfile_pkg::SIZE_16: begin
                    nxt[wb.reg_num][15:0] = wb.data[15:0];
                    wb_on_esp = (wb.reg_num == 3'd4);
                end
                regfile_pkg::SIZE_8: begin
                    // codes 4..7 are AH, CH, DH, BH
                    if (wb.reg_num < 3'd4) begin
                        nxt[wb.reg_num][7:0] = wb.data[7:0];
                    end else begin
                        nxt[wb.reg_num - 3'd4][15:8] = wb.data[7:0];
                    end
                end
                default: begin
                end
            endcase
        end
        if (ew.en && !wb_on_esp) begin
            nxt[4] = ew.data;
        end
        if (sl.esi_en) begin
            nxt[6] = sl.esi_data;
        end
        if (sl.edi_en) begin
            nxt[7] = sl.edi_data;
        end
        return nxt;
    endfunction

    function automatic logic [31:0] sized_read(input model_t s, input logic [2:0] num,
                                               input logic [1:0] size);
        logic [31:0] r;
        r = '0;
        case (size)
            2'd0: r = s[num];
            2'd1: r = {16'h0000, s[num][15:0]};
            2'd2: begin
                if (num < 3'd4) begin
                    r = {24'h000000, s[num][7:0]};
                end else begin
                    r = {24'h000000, s[num - 3'd4][15:8]};
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shadow <= '0;
        end else begin
            shadow <= next_state(shadow, writeback, str_load, esp_write);
        end
    end

    // ------------------------------------------------------------
    // checking and reporting
    // ------------------------------------------------------------

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            mismatch_count++;
            $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("error counts: %0d mismatches, %0d timeouts, %0d cycles checked",
                 mismatch_count, timeout_count, checked_cycles);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // outputs settle well before the next rising edge
    always @(negedge clk) begin
        #1;
        if (checking) begin
            check_word("op_1_value", op_1_value, sized_read(shadow, op_1, register_size));
            check_word("op_2_value", op_2_value, sized_read(shadow, op_2, register_size));
            check_word("sib_base_value", sib_base_value, shadow[sib_base_reg]);
            check_word("sib_index_value", sib_index_value, shadow[sib_index_reg]);
            for (int i = 0; i < regfile_pkg::REG_COUNT; i++) begin
                check_word($sformatf("gpr_state[%0d]", i), gpr_state[i].dword, shadow[i]);
            end
            checked_cycles++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            timeout_count++;
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run();
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #1;
        writeback.en    = 1'b0;
        str_load.esi_en = 1'b0;
        str_load.edi_en = 1'b0;
        esp_write.en    = 1'b0;
    endtask

    task automatic set_writeback(input logic [2:0] num, input regfile_pkg::op_size_e size,
                                 input logic [31:0] data);
        writeback.en      = 1'b1;
        writeback.reg_num = num;
        writeback.size    = size;
        writeback.data    = data;
    endtask

    // every register number at every size, including the reserved one
    task automatic read_sweep();
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 8; n++) begin
                next_cycle();
                register_size = regfile_pkg::op_size_e'(s[1:0]);
                op_1          = n[2:0];
                op_2          = 3'(7 - n);
                sib_base_reg  = n[2:0];
                sib_index_reg = 3'(n + 3);
            end
        end
    endtask

    initial begin
        seed          = 75727;
        arst_n        = 1'b0;
        register_size = regfile_pkg::SIZE_32;
        op_1          = '0;
        op_2          = '0;
        sib_base_reg  = '0;
        sib_index_reg = '0;
        writeback     = '0;
        str_load      = '0;
        esp_write     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        checking = 1'b1;

        // all zero after reset
        read_sweep();

        // full width fill
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            rnd = $random(seed);
            set_writeback(i[2:0], regfile_pkg::SIZE_32, rnd);
        end
        read_sweep();

        // sized merges, then reserved size writes that must change nothing
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            rnd = $random(seed);
            set_writeback(i[2:0], regfile_pkg::SIZE_16, rnd);
        end
        read_sweep();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            rnd = $random(seed);
            set_writeback(i[2:0], regfile_pkg::SIZE_8, rnd);
        end
        read_sweep();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            rnd = $random(seed);
            set_writeback(i[2:0], regfile_pkg::SIZE_RSVD, rnd);
        end
        read_sweep();

        // string loads beat writeback, writeback on ESP beats stack write
        next_cycle();
        set_writeback(regfile_pkg::REG_ESI, regfile_pkg::SIZE_32, 32'h1111_2222);
        str_load.esi_en   = 1'b1;
        str_load.esi_data = 32'h5A5A_0001;
        next_cycle();
        set_writeback(regfile_pkg::REG_EDI, regfile_pkg::SIZE_16, 32'h0000_BEEF);
        str_load.edi_en   = 1'b1;
        str_load.edi_data = 32'hA5A5_0002;
        next_cycle();
        set_writeback(regfile_pkg::REG_ESP, regfile_pkg::SIZE_32, 32'hCAFE_0004);
        esp_write.en   = 1'b1;
        esp_write.data = 32'h0BAD_0004;
        next_cycle();
        esp_write.en   = 1'b1;
        esp_write.data = 32'h0000_7FF0;
        read_sweep();

        // random traffic on every input
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            rnd = $random(seed);
            writeback.en      = rnd[0];
            writeback.reg_num = rnd[3:1];
            writeback.size    = regfile_pkg::op_size_e'(rnd[5:4]);
            str_load.esi_en   = rnd[6] & rnd[7];
            str_load.edi_en   = rnd[8] & rnd[9];
            esp_write.en      = rnd[10];
            register_size     = regfile_pkg::op_size_e'(rnd[12:11]);
            op_1              = rnd[15:13];
            op_2              = rnd[18:16];
            sib_base_reg      = rnd[21:19];
            sib_index_reg     = rnd[24:22];
            writeback.data     = $random(seed);
            str_load.esi_data  = $random(seed);
            str_load.edi_data  = $random(seed);
            esp_write.data     = $random(seed);
        end

        // let the last capture go through a compare
        next_cycle();
        @(negedge clk);
        #2;
        finish_run();
    end

endmodule

`default_nettype wire

//--- files.f
src/regfile_pkg.sv
src/operand_read_port.sv
src/writeback_merge.sv
src/gpr_bank.sv
src/register_file.sv
verification/register_file_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := register_file_tb
FILELIST := files.f
BUILD    := obj_dir
PASS_MSG := All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
